//--- dv/tb_clock_gen.sv
// --------------------------------------------------------------------------
// Testbench clock and reset
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk42m,
	output logic ff_reset_n
);

	initial begin
		clk42m = 1'b0;
		forever #4 clk42m = ~clk42m;		// 8 ns period
	end

	initial begin
		ff_reset_n = 1'b0;
		repeat (2) @(posedge clk42m);		// Two cycles in reset
		#1 ff_reset_n = 1'b1;
	end

endmodule

//--- dv/tb_msx_slot_bridge.sv
// --------------------------------------------------------------------------
// MSX slot bridge directed tests
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_msx_slot_bridge;

	localparam int timeout_cycles = 4000;		// ~220 accesses of 14 cycles

	logic clk42m, ff_reset_n, sdram_init_busy;
	logic mreq_n, iorq_n, rd_n, wr_n, sdram_q_en, cpu_enable;
	logic sdram_mreq_n, sdram_rd_n, sdram_wr_n;
	logic [15:0] a;
	logic [7:0]  cpu_wdata, sdram_q, cpu_rdata;
	logic [22:0] sdram_address;

	// Model of the slot registers, kept from the writes issued
	logic [7:0]  prim, sec0, sec3;
	// Values seen early in the access and at its end
	logic [22:0] smp_addr;
	logic        smp_rd_n, smp_wr_n, smp_mreq_n;
	logic [7:0]  last_rdata;
	int          cycle_count = 0;

	tb_clock_gen clock_i (.clk42m(clk42m), .ff_reset_n(ff_reset_n));

	msx_slot_bridge dut_i (
		.clk42m(clk42m), .ff_reset_n(ff_reset_n), .sdram_init_busy(sdram_init_busy),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .a(a),
		.cpu_wdata(cpu_wdata), .cpu_enable(cpu_enable), .cpu_rdata(cpu_rdata),
		.sdram_q(sdram_q), .sdram_q_en(sdram_q_en), .sdram_address(sdram_address),
		.sdram_mreq_n(sdram_mreq_n), .sdram_rd_n(sdram_rd_n), .sdram_wr_n(sdram_wr_n)
	);

	// Run limit
	always @(posedge clk42m) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("Test failed");
			$fatal(1);
		end
	end

	// --------------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// One bus cycle, strobes held 12 clocks; optional sdram_q_en pulse
	task automatic run_access(input logic io, input logic wr, input logic [15:0] addr,
			input logic [7:0] wd, input logic pulse, input logic [7:0] qbyte);
		int i;
		a         = addr;
		cpu_wdata = wd;
		if (io) iorq_n = 1'b0;
		else mreq_n = 1'b0;
		if (wr) wr_n = 1'b0;
		else rd_n = 1'b0;
		@(negedge clk42m);					// Before any register write of this access
		smp_addr   = sdram_address;
		smp_rd_n   = sdram_rd_n;
		smp_wr_n   = sdram_wr_n;
		smp_mreq_n = sdram_mreq_n;
		for (i = 0; i < 11; i++) begin
			@(posedge clk42m);
			#1;
			sdram_q_en = (pulse && i == 5);		// One-cycle SDRAM data strobe
			if (pulse && i == 5) sdram_q = qbyte;
		end
		@(posedge clk42m);
		#1;
		last_rdata = cpu_rdata;				// Registered on the last edge of the read
		mreq_n     = 1'b1;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		sdram_q_en = 1'b0;
		repeat (2) @(posedge clk42m);
		#1;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		run_access(1'b1, 1'b1, {8'h00, port}, data, 1'b0, 8'h00);
		if (port[7:2] == 6'b1010_10) prim = data;
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		run_access(1'b0, 1'b1, addr, data, 1'b0, 8'h00);
		if (addr == 16'hFFFF && prim[7:6] == 2'd0) sec0 = data;
		if (addr == 16'hFFFF && prim[7:6] == 2'd3) sec3 = data;
	endtask

	// Expected {upper 10 bits, rd_n, wr_n} from the region table
	function automatic logic [11:0] expect_map(input logic [15:0] addr, input logic is_wr);
		logic [1:0] pg, ps, sub;
		logic [9:0] up;
		logic rd_ok, ram, hit;
		pg    = addr[15:14];
		ps    = prim[2*pg +: 2];
		sub   = (ps == 2'd0) ? sec0[2*pg +: 2] : (ps == 2'd3) ? sec3[2*pg +: 2] : 2'd0;
		hit   = (addr == 16'hFFFF) && (prim[7:6] == 2'd0 || prim[7:6] == 2'd3);
		ram   = 1'b0;
		rd_ok = 1'b0;
		up    = 10'd0;
		if (ps == 2'd3 && sub == 2'd0) begin
			up = {7'b1000000, addr[15:13]};
			rd_ok = 1'b1;
			ram = 1'b1;
		end
		else if (ps == 2'd1) begin
			up = {7'b0100000, addr[15:13]};
			rd_ok = 1'b1;
		end
		else if (ps == 2'd2) begin
			up = 10'b0000100000;
			rd_ok = (pg == 2'd1 || pg == 2'd2);
		end
		else if (ps == 2'd0 && sub == 2'd3) begin
			up = {8'b00000111, addr[14:13]};
			rd_ok = (pg == 2'd1 || pg == 2'd2);
		end
		else if (ps == 2'd0 && sub == 2'd2) begin
			up = {9'b000000110, addr[13]};
			rd_ok = (pg == 2'd1);
		end
		else if (ps == 2'd0 && sub == 2'd1) begin
			up = {9'b000001100, addr[13]};
			rd_ok = (pg == 2'd1);
		end
		else if (ps == 2'd3 && sub == 2'd1) begin
			up = {8'b00000101, addr[14:13]};
			rd_ok = (pg == 2'd0 || pg == 2'd1);
		end
		else if (ps == 2'd0 && sub == 2'd0) begin
			up = {8'b00000100, addr[14:13]};
			rd_ok = (pg == 2'd0 || pg == 2'd1);
		end
		else if (ps == 2'd3 && sub == 2'd2) begin
			up = {7'b0000000, addr[15:13]};
			rd_ok = (pg == 2'd1 || pg == 2'd2);
		end
		return {up, !(!is_wr && rd_ok && !hit), !(is_wr && ram && !hit)};
	endfunction

	// --------------------------------------------------------------------------
	// Tests
	// --------------------------------------------------------------------------
	task automatic test_clock_enable();
		int i;
		@(posedge ff_reset_n);
		for (i = 1; i <= 60; i++) begin
			@(posedge clk42m);
			@(negedge clk42m);
			check_value("cpu_enable", cpu_enable, (i % 12) == 11);	// Counter hits 11
		end
		@(posedge clk42m);
		#1 sdram_init_busy = 1'b1;
		for (i = 0; i < 36; i++) begin
			@(negedge clk42m);
			check_value("cpu_enable (busy)", cpu_enable, 1'b0);
		end
		@(posedge clk42m);
		#1 sdram_init_busy = 1'b0;
	endtask

	task automatic test_primary_slot();
		logic [7:0] val;
		val = 8'($urandom);
		io_write(8'hA8, val);
		run_access(1'b1, 1'b0, 16'h00A8, 8'h00, 1'b0, 8'h00);
		check_value("cpu_rdata (A8)", last_rdata, val);
		val = 8'($urandom);
		io_write(8'hAB, val);
		run_access(1'b1, 1'b0, 16'h00AA, 8'h00, 1'b0, 8'h00);
		check_value("cpu_rdata (AB)", last_rdata, val);
		run_access(1'b1, 1'b0, 16'h0042, 8'h00, 1'b0, 8'h00);	// Nothing answers
		check_value("cpu_rdata (unmapped)", last_rdata, 8'hFF);
	endtask

	task automatic test_secondary_slot();
		logic [7:0] val;
		logic [7:0] inv;
		val = 8'($urandom);
		inv = ~val;							// Register reads back inverted
		io_write(8'hA8, 8'hC0);				// Page 3 in slot 3
		mem_write(16'hFFFF, val);
		run_access(1'b0, 1'b0, 16'hFFFF, 8'h00, 1'b0, 8'h00);
		check_value("cpu_rdata (FFFF)", last_rdata, inv);
		check_value("sdram_rd_n (FFFF)", smp_rd_n, 1'b1);
		io_write(8'hA8, 8'h40);				// Page 3 in slot 1
		run_access(1'b0, 1'b0, 16'hFFFF, 8'h00, 1'b0, 8'h00);
		check_value("sdram_rd_n (slot 1)", smp_rd_n, 1'b0);
		check_value("cpu_rdata (slot 1)", last_rdata, 8'hFF);
	endtask

	task automatic test_memory_map();
		int n;
		logic [15:0] addr;
		logic [11:0] exp;
		logic [7:0] pbyte;
		for (n = 0; n < 60; n++) begin
			if (n % 10 == 0) begin
				io_write(8'hA8, 8'h00);
				mem_write(16'hFFFF, 8'($urandom));
				io_write(8'hA8, 8'hC0);
				mem_write(16'hFFFF, 8'($urandom));
			end
			pbyte = 8'($urandom);
			io_write(8'hA9, pbyte);
			addr = (n % 15 == 7) ? 16'hFFFF : 16'($urandom);
			exp = expect_map(addr, 1'b0);
			run_access(1'b0, 1'b0, addr, 8'h00, 1'b0, 8'h00);
			check_value("sdram_address (rd)", smp_addr, {exp[11:2], addr[12:0]});
			check_value("sdram_rd_n (rd)", smp_rd_n, exp[1]);
			check_value("sdram_wr_n (rd)", smp_wr_n, 1'b1);
			check_value("sdram_mreq_n", smp_mreq_n, 1'b0);
			exp = expect_map(addr, 1'b1);
			mem_write(addr, 8'($urandom));
			check_value("sdram_address (wr)", smp_addr, {exp[11:2], addr[12:0]});
			check_value("sdram_rd_n (wr)", smp_rd_n, 1'b1);
			check_value("sdram_wr_n (wr)", smp_wr_n, exp[0]);
		end
	endtask

	task automatic test_read_priority();
		logic [7:0] qbyte;
		qbyte = 8'($urandom);
		io_write(8'hA8, 8'h55);				// Every page in slot 1
		run_access(1'b0, 1'b0, 16'h4123, 8'h00, 1'b1, qbyte);
		check_value("sdram_rd_n (mapped)", smp_rd_n, 1'b0);
		check_value("cpu_rdata (sdram)", last_rdata, qbyte);
		@(negedge clk42m);
		check_value("cpu_rdata (idle)", cpu_rdata, 8'hFF);
		@(posedge clk42m);
		#1;
	endtask

	// --------------------------------------------------------------------------
	// Main sequence
	// --------------------------------------------------------------------------
	initial begin
		void'($urandom(32'h8cfd_aaca));
		sdram_init_busy = 1'b0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		a = 16'h0000;
		cpu_wdata = 8'h00;
		sdram_q = 8'h00;
		sdram_q_en = 1'b0;
		prim = 8'h00;
		sec0 = 8'h00;
		sec3 = 8'h00;
		test_clock_enable();
		test_primary_slot();
		test_secondary_slot();
		test_memory_map();
		test_read_priority();
		$display("Test passed");
		$finish;
	end

endmodule

//--- msx_slot_bridge.f
verilog/msx_bus_pkg.sv
verilog/cpu_bus_if.sv
verilog/cpu_clock_enable.sv
verilog/slot_select.sv
verilog/sdram_map.sv
verilog/read_data_mux.sv
verilog/msx_slot_bridge.sv
dv/tb_clock_gen.sv
dv/tb_msx_slot_bridge.sv

//--- verilog/cpu_bus_if.sv
// --------------------------------------------------------------------------
// Internal CPU bus
// --------------------------------------------------------------------------
`timescale 1ns/10ps

interface cpu_bus_if;
	import msx_bus_pkg::*;

	logic       mreq_n;			// Memory request
	logic       iorq_n;			// I/O request
	logic       rd_n;			// Read strobe
	logic       wr_n;			// Write strobe
	cpu_addr_t  a;				// CPU address
	logic [7:0] wdata;			// CPU write data
	logic       enable;			// CPU clock enable

	// Slot registers see the whole bus
	modport slot_side (
		input mreq_n, iorq_n, rd_n, wr_n, a, wdata, enable
	);

	// Memory map needs only strobes and address
	modport map_side (
		input mreq_n, iorq_n, rd_n, wr_n, a
	);

	// Read mux only watches rd_n
	modport mux_side (
		input rd_n
	);

endinterface

//--- verilog/cpu_clock_enable.sv
// --------------------------------------------------------------------------
// CPU clock enable
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module cpu_clock_enable (
	input  logic clk42m,
	input  logic ff_reset_n,
	input  logic sdram_init_busy,		// SDRAM still initialising
	output logic cpu_enable				// One pulse per period
);
	import msx_bus_pkg::*;

	logic [cpu_div_width-1:0] ff_count;		// Phase counter
	logic                     w_last;		// Final phase of the period

	// --------------------------------------------------------------------------
	// Modulo-twelve phase counter
	// --------------------------------------------------------------------------
	assign w_last = (ff_count == cpu_div_width'(cpu_enable_period - 1));

	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_count <= '0;
		end
		else if (w_last) begin
			ff_count <= '0;					// Wrap
		end
		else begin
			ff_count <= ff_count + 1'b1;
		end
	end

	// Counter keeps running during SDRAM init, only the pulse is held off
	assign cpu_enable = w_last && !sdram_init_busy;

endmodule

//--- verilog/msx_bus_pkg.sv
// --------------------------------------------------------------------------
// MSX slot bridge shared definitions
// --------------------------------------------------------------------------

package msx_bus_pkg;

	// Bus widths
	typedef logic [15:0] cpu_addr_t;		// Z80 address
	typedef logic [22:0] sdram_addr_t;		// SDRAM byte address, 8MB

	// One slot register byte
	// Page 0 lives in bits 1:0, page 3 in bits 7:6
	typedef union packed {
		logic [7:0]      value;				// Whole byte for write and read-back
		logic [3:0][1:0] page;				// Per-page slot number
	} slot_reg_t;

	// --------------------------------------------------------------------------
	// Bus decode constants
	// --------------------------------------------------------------------------
	localparam logic [7:0]  ppi_slot_port = 8'hA8;		// A8h..ABh, low 2 bits ignored
	localparam logic [15:0] sec_slot_addr = 16'hFFFF;	// Expanded slot register

	localparam int cpu_enable_period = 12;				// clk42m cycles per CPU tick
	localparam int cpu_div_width     = $clog2(cpu_enable_period);

	localparam logic [7:0] idle_rdata = 8'hFF;			// Open bus value

	// --------------------------------------------------------------------------
	// Memory map, upper SDRAM address bits per region
	// --------------------------------------------------------------------------
	// Slot 3-0, mapper RAM, followed by a[15:13]
	localparam logic [6:0] map_ram_base    = 7'b100_0000;
	// Slot 1, mega ROM, followed by a[15:13]
	localparam logic [6:0] map_mega_base   = 7'b010_0000;
	// Slot 2, fixed ROM
	localparam logic [9:0] map_fixed_base  = 10'b00_0010_0000;
	// Slot 0-3, logo and extended BASIC, followed by a[14:13]
	localparam logic [7:0] map_logo_base   = 8'b0000_0111;
	// Slot 0-2, music ROM, followed by a[13]
	localparam logic [8:0] map_music_base  = 9'b0_0000_0110;
	// Slot 0-1, followed by a[13]
	localparam logic [8:0] map_slot01_base = 9'b0_0000_1100;
	// Slot 3-1, sub ROM, followed by a[14:13]
	localparam logic [7:0] map_sub_base    = 8'b0000_0101;
	// Slot 0-0, main ROM, followed by a[14:13]
	localparam logic [7:0] map_main_base   = 8'b0000_0100;
	// Slot 3-2, disk ROM, followed by a[15:13]
	localparam logic [6:0] map_disk_base   = 7'b000_0000;
	// Slot 3-3, nothing fitted
	localparam logic [9:0] map_none_base   = 10'b00_0000_0000;

endpackage

//--- verilog/msx_slot_bridge.sv
// --------------------------------------------------------------------------
// MSX slot bridge top level
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module msx_slot_bridge (
	input  logic                      clk42m,
	input  logic                      ff_reset_n,
	input  logic                      sdram_init_busy,	// SDRAM init in progress
	// Z80 bus
	input  logic                      mreq_n,
	input  logic                      iorq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  msx_bus_pkg::cpu_addr_t    a,
	input  logic [7:0]                cpu_wdata,
	output logic                      cpu_enable,		// CPU clock enable
	output logic [7:0]                cpu_rdata,
	// SDRAM request side
	input  logic [7:0]                sdram_q,
	input  logic                      sdram_q_en,
	output msx_bus_pkg::sdram_addr_t  sdram_address,
	output logic                      sdram_mreq_n,
	output logic                      sdram_rd_n,
	output logic                      sdram_wr_n
);

	logic [1:0] w_page_slot;		// Primary slot of current page
	logic [1:0] w_page_sub;			// Secondary slot of current page
	logic       w_slot_reg_hit;		// FFFFh register access
	logic [7:0] w_slot_q;
	logic       w_slot_q_en;

	// --------------------------------------------------------------------------
	// Internal CPU bus
	// --------------------------------------------------------------------------
	cpu_bus_if u_bus ();

	assign u_bus.mreq_n = mreq_n;
	assign u_bus.iorq_n = iorq_n;
	assign u_bus.rd_n   = rd_n;
	assign u_bus.wr_n   = wr_n;
	assign u_bus.a      = a;
	assign u_bus.wdata  = cpu_wdata;
	assign u_bus.enable = cpu_enable;

	// --------------------------------------------------------------------------
	// Blocks
	// --------------------------------------------------------------------------
	cpu_clock_enable u_clock_enable (
		.clk42m          (clk42m),
		.ff_reset_n      (ff_reset_n),
		.sdram_init_busy (sdram_init_busy),
		.cpu_enable      (cpu_enable)
	);

	slot_select u_slot_select (
		.clk42m       (clk42m),
		.ff_reset_n   (ff_reset_n),
		.bus          (u_bus.slot_side),
		.page_slot    (w_page_slot),
		.page_sub     (w_page_sub),
		.slot_reg_hit (w_slot_reg_hit),
		.slot_q       (w_slot_q),
		.slot_q_en    (w_slot_q_en)
	);

	sdram_map u_sdram_map (
		.bus           (u_bus.map_side),
		.page_slot     (w_page_slot),
		.page_sub      (w_page_sub),
		.slot_reg_hit  (w_slot_reg_hit),
		.sdram_address (sdram_address),
		.sdram_mreq_n  (sdram_mreq_n),
		.sdram_rd_n    (sdram_rd_n),
		.sdram_wr_n    (sdram_wr_n)
	);

	read_data_mux u_read_data_mux (
		.clk42m     (clk42m),
		.bus        (u_bus.mux_side),
		.slot_q     (w_slot_q),
		.slot_q_en  (w_slot_q_en),
		.sdram_q    (sdram_q),
		.sdram_q_en (sdram_q_en),
		.cpu_rdata  (cpu_rdata)
	);

endmodule

//--- verilog/read_data_mux.sv
// --------------------------------------------------------------------------
// CPU read data multiplexer
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module read_data_mux (
	input  logic          clk42m,
	cpu_bus_if.mux_side   bus,
	input  logic [7:0]    slot_q,			// Slot register data
	input  logic          slot_q_en,
	input  logic [7:0]    sdram_q,			// SDRAM read data
	input  logic          sdram_q_en,		// End of SDRAM latency
	output logic [7:0]    cpu_rdata			// Data seen by the CPU
);
	import msx_bus_pkg::*;

	logic [7:0] ff_rdata;		// Held read byte

	// --------------------------------------------------------------------------
	// Priority select
	// --------------------------------------------------------------------------
	// Slot registers first, then SDRAM, then open bus when idle
	always_ff @(posedge clk42m) begin
		if (slot_q_en) begin
			ff_rdata <= slot_q;
		end
		else if (sdram_q_en) begin
			ff_rdata <= sdram_q;
		end
		else if (bus.rd_n) begin
			ff_rdata <= idle_rdata;			// No read in progress
		end
		else begin
			ff_rdata <= ff_rdata;			// Hold until the read ends
		end
	end

	assign cpu_rdata = ff_rdata;

endmodule

//--- verilog/sdram_map.sv
// --------------------------------------------------------------------------
// SDRAM memory map
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module sdram_map (
	cpu_bus_if.map_side               bus,
	input  logic [1:0]                page_slot,		// Primary slot of page
	input  logic [1:0]                page_sub,			// Secondary slot of page
	input  logic                      slot_reg_hit,		// FFFFh register access
	output msx_bus_pkg::sdram_addr_t  sdram_address,
	output logic                      sdram_mreq_n,
	output logic                      sdram_rd_n,
	output logic                      sdram_wr_n
);
	import msx_bus_pkg::*;

	logic [9:0] w_upper;			// SDRAM address bits 22:13
	logic       w_read_page;		// Region readable on this page
	logic       w_ram;				// Slot 3-0 mapper RAM
	logic [1:0] w_page;				// Current 16KB page
	logic       w_mid_pages;		// Page 1 or 2
	logic       w_low_pages;		// Page 0 or 1
	logic       w_page1;			// Page 1 only

	assign w_page      = bus.a[15:14];
	assign w_mid_pages = (w_page == 2'd1) || (w_page == 2'd2);
	assign w_low_pages = !bus.a[15];
	assign w_page1     = (w_page == 2'd1);

	// --------------------------------------------------------------------------
	// Region table
	// --------------------------------------------------------------------------
	always_comb begin
		w_upper     = map_none_base;
		w_read_page = 1'b0;
		w_ram       = 1'b0;
		case (page_slot)
			2'd0: begin
				case (page_sub)
					2'd0: begin
						w_upper     = {map_main_base, bus.a[14:13]};	// Main ROM
						w_read_page = w_low_pages;
					end
					2'd1: begin
						w_upper     = {map_slot01_base, bus.a[13]};
						w_read_page = w_page1;
					end
					2'd2: begin
						w_upper     = {map_music_base, bus.a[13]};		// Music ROM
						w_read_page = w_page1;
					end
					default: begin
						w_upper     = {map_logo_base, bus.a[14:13]};	// Logo, ext BASIC
						w_read_page = w_mid_pages;
					end
				endcase
			end
			2'd1: begin
				w_upper     = {map_mega_base, bus.a[15:13]};			// Mega ROM
				w_read_page = 1'b1;
			end
			2'd2: begin
				w_upper     = map_fixed_base;							// Fixed ROM
				w_read_page = w_mid_pages;
			end
			default: begin
				case (page_sub)
					2'd0: begin
						w_upper     = {map_ram_base, bus.a[15:13]};		// Mapper RAM
						w_read_page = 1'b1;
						w_ram       = 1'b1;
					end
					2'd1: begin
						w_upper     = {map_sub_base, bus.a[14:13]};		// Sub ROM
						w_read_page = w_low_pages;
					end
					2'd2: begin
						w_upper     = {map_disk_base, bus.a[15:13]};	// Disk ROM
						w_read_page = w_mid_pages;
					end
					default: begin
						w_upper     = map_none_base;					// 3-3 empty
						w_read_page = 1'b0;
					end
				endcase
			end
		endcase
	end

	// --------------------------------------------------------------------------
	// SDRAM request
	// --------------------------------------------------------------------------
	assign sdram_address = {w_upper, bus.a[12:0]};
	assign sdram_mreq_n  = bus.mreq_n;

	// I/O cycles and slot register reads never touch SDRAM
	assign sdram_rd_n = (!bus.iorq_n || slot_reg_hit) ? 1'b1 :
						(w_read_page)                 ? bus.rd_n :
														1'b1;

	assign sdram_wr_n = (w_ram && !slot_reg_hit) ? bus.wr_n : 1'b1;	// RAM only

endmodule

//--- verilog/slot_select.sv
// --------------------------------------------------------------------------
// Primary and secondary slot registers
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module slot_select (
	input  logic              clk42m,
	input  logic              ff_reset_n,
	cpu_bus_if.slot_side      bus,
	output logic [1:0]        page_slot,		// Primary slot of current page
	output logic [1:0]        page_sub,			// Secondary slot of current page
	output logic              slot_reg_hit,		// Access to FFFFh register
	output logic [7:0]        slot_q,			// Register read data
	output logic              slot_q_en			// Read data valid
);
	import msx_bus_pkg::*;

	slot_reg_t  ff_primary;			// A8h register
	slot_reg_t  ff_sec0;			// Expanded slot 0
	slot_reg_t  ff_sec3;			// Expanded slot 3

	logic [1:0] w_page;				// Current 16KB page
	logic       w_io_hit;			// I/O access to A8h..ABh
	logic       w_sec_addr;			// Memory access to FFFFh
	logic       w_sec0_sel;			// FFFFh lands on slot 0 register
	logic       w_sec3_sel;			// FFFFh lands on slot 3 register
	logic       w_write;			// Qualified write cycle

	// --------------------------------------------------------------------------
	// Address decode
	// --------------------------------------------------------------------------
	assign w_page     = bus.a[15:14];
	assign w_io_hit   = !bus.iorq_n && ({bus.a[7:2], 2'b00} == ppi_slot_port);
	assign w_sec_addr = !bus.mreq_n && (bus.a == sec_slot_addr);

	// Page 3 primary slot picks which secondary register answers
	assign w_sec0_sel = w_sec_addr && (ff_primary.page[3] == 2'd0);
	assign w_sec3_sel = w_sec_addr && (ff_primary.page[3] == 2'd3);

	assign slot_reg_hit = w_sec0_sel || w_sec3_sel;

	assign w_write = bus.enable && !bus.wr_n;		// One write per CPU tick

	// --------------------------------------------------------------------------
	// Register writes
	// --------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_primary.value <= 8'h00;
			ff_sec0.value    <= 8'h00;
			ff_sec3.value    <= 8'h00;
		end
		else if (w_write) begin
			if (w_io_hit) begin
				ff_primary.value <= bus.wdata;
			end
			if (w_sec0_sel) begin
				ff_sec0.value <= bus.wdata;
			end
			if (w_sec3_sel) begin
				ff_sec3.value <= bus.wdata;
			end
		end
	end

	// --------------------------------------------------------------------------
	// Current slot of the access
	// --------------------------------------------------------------------------
	assign page_slot = ff_primary.page[w_page];

	always_comb begin
		case (page_slot)
			2'd0: page_sub = ff_sec0.page[w_page];		// Expanded slot 0
			2'd3: page_sub = ff_sec3.page[w_page];		// Expanded slot 3
			default: page_sub = 2'd0;					// Slots 1 and 2 not expanded
		endcase
	end

	// --------------------------------------------------------------------------
	// Read-back
	// --------------------------------------------------------------------------
	always_comb begin
		slot_q_en = 1'b0;
		slot_q    = ff_primary.value;
		if (!bus.rd_n) begin
			if (w_sec0_sel) begin
				slot_q_en = 1'b1;
				slot_q    = ~ff_sec0.value;		// Secondary reads back inverted
			end
			else if (w_sec3_sel) begin
				slot_q_en = 1'b1;
				slot_q    = ~ff_sec3.value;
			end
			else if (w_io_hit) begin
				slot_q_en = 1'b1;				// Primary byte as is
			end
		end
	end

endmodule
